// ==== hw/dmi_pkg.sv ====
// --------------------------------------
// Shared widths, depths and types for the debug-memory harness.
// Every RTL file reaches these by scoped names.
// --------------------------------------
`default_nettype none

package dmi_pkg;

  // --------------------------------------
  // Sizes
  // --------------------------------------
  localparam int unsigned AddrWidth      = 7;
  localparam int unsigned DataWidth      = 32;
  localparam int unsigned MemWords       = 64;
  localparam int unsigned FifoDepth      = 4;
  localparam int unsigned BootHoldCycles = 16;

  // Derived counter and index widths
  localparam int unsigned MemIdxWidth  = $clog2(MemWords);
  localparam int unsigned FifoPtrWidth = $clog2(FifoDepth);
  localparam int unsigned FifoCntWidth = $clog2(FifoDepth + 1);
  localparam int unsigned HoldCntWidth = $clog2(BootHoldCycles + 1);

  typedef logic [MemIdxWidth-1:0]  mem_idx_t;
  typedef logic [FifoPtrWidth-1:0] fifo_ptr_t;
  typedef logic [FifoCntWidth-1:0] fifo_cnt_t;
  typedef logic [HoldCntWidth-1:0] hold_cnt_t;

  // --------------------------------------
  // Request and response encodings
  // --------------------------------------
  // Code 3 is reserved, the target treats it as a NOP
  typedef enum logic [1:0] {
    DMI_NOP   = 2'd0,
    DMI_READ  = 2'd1,
    DMI_WRITE = 2'd2
  } dmi_op_e;

  typedef enum logic [1:0] {
    DMI_OK     = 2'd0,
    DMI_FAILED = 2'd2
  } dmi_resp_e;

  // One request word, 41 bits
  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    dmi_op_e              op;
    logic [DataWidth-1:0] data;
  } dmi_req_t;

endpackage

`default_nettype wire

// ==== hw/dmi_req_if.sv ====
// --------------------------------------
// Valid/ready request channel between harness blocks.
// The sender uses src, the receiver uses dst.
// --------------------------------------
`timescale 1ns/1ns
`default_nettype none

interface dmi_req_if;

  logic              valid;
  logic              ready;
  dmi_pkg::dmi_req_t req;

  // Sender side
  modport src (
    output valid,
    output req,
    input  ready
  );

  // Receiver side
  modport dst (
    input  valid,
    input  req,
    output ready
  );

endinterface

`default_nettype wire

// ==== hw/dmi_req_gate.sv ====
// --------------------------------------
// Picks the JTAG or DTM request source and masks
// all requests during the boot window after reset.
// --------------------------------------
`timescale 1ns/1ns
`default_nettype none

module dmi_req_gate (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              jtag_sel_i,
  input  logic              jtag_valid_i,
  input  dmi_pkg::dmi_req_t jtag_req_i,
  output logic              jtag_ready_o,
  input  logic              dtm_valid_i,
  input  dmi_pkg::dmi_req_t dtm_req_i,
  output logic              dtm_ready_o,
  dmi_req_if.src            req_o
);

  dmi_pkg::hold_cnt_t hold_cnt_q;
  logic               hold_active;
  logic               sel_valid;

  // --------------------------------------
  // Boot hold counter
  // --------------------------------------
  assign hold_active = (hold_cnt_q != '0);

  // Loaded at reset, counts down once per cycle and parks at zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hold_cnt_q <= dmi_pkg::hold_cnt_t'(dmi_pkg::BootHoldCycles);
    end else if (hold_active) begin
      hold_cnt_q <= hold_cnt_q - 1'b1;
    end
  end

  // --------------------------------------
  // Source select
  // --------------------------------------
  assign sel_valid = jtag_sel_i ? jtag_valid_i : dtm_valid_i;

  assign req_o.valid = sel_valid & ~hold_active;
  assign req_o.req   = jtag_sel_i ? jtag_req_i : dtm_req_i;

  // Ready only goes back to the selected source
  assign jtag_ready_o = req_o.ready & ~hold_active & jtag_sel_i;
  assign dtm_ready_o  = req_o.ready & ~hold_active & ~jtag_sel_i;

  // --------------------------------------
  // Checks
  // --------------------------------------
  // A transfer needs reset released for at least the whole boot window
  a_no_xfer_in_hold: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    req_o.valid && req_o.ready |-> $past(rst_ni, dmi_pkg::BootHoldCycles)
  );

endmodule

`default_nettype wire

// ==== hw/dmi_req_fifo.sv ====
// --------------------------------------
// Request buffer of FifoDepth entries between the gate
// and the memory target. Push and pop may share a cycle.
// --------------------------------------
`timescale 1ns/1ns
`default_nettype none

module dmi_req_fifo (
  input  logic   clk_i,
  input  logic   rst_ni,
  dmi_req_if.dst req_i,
  dmi_req_if.src req_o
);

  dmi_pkg::dmi_req_t  mem_q [dmi_pkg::FifoDepth];
  dmi_pkg::fifo_ptr_t wr_ptr_q;
  dmi_pkg::fifo_ptr_t rd_ptr_q;
  dmi_pkg::fifo_cnt_t count_q;
  logic               push;
  logic               pop;
  logic               full;
  logic               empty;

  assign full  = (count_q == dmi_pkg::fifo_cnt_t'(dmi_pkg::FifoDepth));
  assign empty = (count_q == '0);

  assign req_i.ready = ~full;
  assign req_o.valid = ~empty;
  assign req_o.req   = mem_q[rd_ptr_q];

  assign push = req_i.valid & req_i.ready;
  assign pop  = req_o.valid & req_o.ready;

  // --------------------------------------
  // Pointers and fill level
  // --------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == dmi_pkg::fifo_ptr_t'(dmi_pkg::FifoDepth - 1)) ?
                    '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == dmi_pkg::fifo_ptr_t'(dmi_pkg::FifoDepth - 1)) ?
                    '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Entry storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= req_i.req;
    end
  end

  // --------------------------------------
  // Checks
  // --------------------------------------
  a_count_bound: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    count_q <= dmi_pkg::fifo_cnt_t'(dmi_pkg::FifoDepth)
  );

  // Head entry holds while the target is not taking it
  a_head_stable: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    req_o.valid && !req_o.ready |=> req_o.valid && $stable(req_o.req)
  );

endmodule

`default_nettype wire

// ==== hw/dmi_mem_target.sv ====
// --------------------------------------
// Word memory that executes NOP, READ and WRITE requests
// and returns one registered response per request.
// --------------------------------------
`timescale 1ns/1ns
`default_nettype none

module dmi_mem_target (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  dmi_req_if.dst                        req_i,
  output logic                          resp_valid_o,
  output logic [dmi_pkg::DataWidth-1:0] resp_data_o,
  output dmi_pkg::dmi_resp_e            resp_code_o,
  input  logic                          resp_ready_i
);

  logic [dmi_pkg::DataWidth-1:0] mem_q [dmi_pkg::MemWords];
  dmi_pkg::mem_idx_t             mem_idx;
  logic                          in_range;
  logic                          take;
  logic                          mem_we;

  logic                          resp_valid_q;
  logic [dmi_pkg::DataWidth-1:0] resp_data_q;
  logic [dmi_pkg::DataWidth-1:0] resp_data_d;
  dmi_pkg::dmi_resp_e            resp_code_q;
  dmi_pkg::dmi_resp_e            resp_code_d;

  // Accept when the response slot is free or drains this cycle
  assign req_i.ready = ~resp_valid_q | resp_ready_i;
  assign take        = req_i.valid & req_i.ready;

  assign in_range = (32'(req_i.req.addr) < dmi_pkg::MemWords);
  assign mem_idx  = dmi_pkg::mem_idx_t'(req_i.req.addr);

  // --------------------------------------
  // Request decode
  // --------------------------------------
  always_comb begin
    resp_data_d = '0;
    resp_code_d = dmi_pkg::DMI_OK;
    mem_we      = 1'b0;
    case (req_i.req.op)
      dmi_pkg::DMI_READ: begin
        if (in_range) begin
          resp_data_d = mem_q[mem_idx];
        end else begin
          resp_code_d = dmi_pkg::DMI_FAILED;
        end
      end
      dmi_pkg::DMI_WRITE: begin
        if (in_range) begin
          mem_we = take;
        end else begin
          resp_code_d = dmi_pkg::DMI_FAILED;
        end
      end
      // NOP and the reserved code
      default: begin
        resp_code_d = dmi_pkg::DMI_OK;
      end
    endcase
  end

  // --------------------------------------
  // Memory and response registers
  // --------------------------------------
  // Read data above comes from the old contents, before this write lands
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < dmi_pkg::MemWords; i++) begin
        mem_q[i] <= '0;
      end
    end else if (mem_we) begin
      mem_q[mem_idx] <= req_i.req.data;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      resp_valid_q <= 1'b0;
    end else if (take) begin
      resp_valid_q <= 1'b1;
    end else if (resp_ready_i) begin
      resp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      resp_data_q <= resp_data_d;
      resp_code_q <= resp_code_d;
    end
  end

  assign resp_valid_o = resp_valid_q;
  assign resp_data_o  = resp_data_q;
  assign resp_code_o  = resp_code_q;

  // Stalled response must hold until the consumer takes it
  a_resp_stable: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    resp_valid_o && !resp_ready_i |=>
      resp_valid_o && $stable(resp_data_o) && $stable(resp_code_o)
  );

endmodule

`default_nettype wire

// ==== hw/dmi_mem_harness.sv ====
// --------------------------------------
// Top level of the debug-memory harness. Two request ports
// feed one gate, a request FIFO and the memory target.
// --------------------------------------
`timescale 1ns/1ns
`default_nettype none

module dmi_mem_harness (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          jtag_sel_i,
  // JTAG-side request port
  input  logic                          jtag_req_valid_i,
  input  logic [dmi_pkg::AddrWidth-1:0] jtag_req_addr_i,
  input  dmi_pkg::dmi_op_e              jtag_req_op_i,
  input  logic [dmi_pkg::DataWidth-1:0] jtag_req_data_i,
  output logic                          jtag_req_ready_o,
  // DTM-side request port
  input  logic                          dtm_req_valid_i,
  input  logic [dmi_pkg::AddrWidth-1:0] dtm_req_addr_i,
  input  dmi_pkg::dmi_op_e              dtm_req_op_i,
  input  logic [dmi_pkg::DataWidth-1:0] dtm_req_data_i,
  output logic                          dtm_req_ready_o,
  // Response port
  output logic                          resp_valid_o,
  output logic [dmi_pkg::DataWidth-1:0] resp_data_o,
  output dmi_pkg::dmi_resp_e            resp_code_o,
  input  logic                          resp_ready_i
);

  dmi_pkg::dmi_req_t jtag_req;
  dmi_pkg::dmi_req_t dtm_req;

  // Pack the flat port fields into request words
  assign jtag_req.addr = jtag_req_addr_i;
  assign jtag_req.op   = jtag_req_op_i;
  assign jtag_req.data = jtag_req_data_i;

  assign dtm_req.addr = dtm_req_addr_i;
  assign dtm_req.op   = dtm_req_op_i;
  assign dtm_req.data = dtm_req_data_i;

  dmi_req_if gate_to_fifo ();
  dmi_req_if fifo_to_mem ();

  dmi_req_gate i_gate (
    .clk_i        ( clk_i            ),
    .rst_ni       ( rst_ni           ),
    .jtag_sel_i   ( jtag_sel_i       ),
    .jtag_valid_i ( jtag_req_valid_i ),
    .jtag_req_i   ( jtag_req         ),
    .jtag_ready_o ( jtag_req_ready_o ),
    .dtm_valid_i  ( dtm_req_valid_i  ),
    .dtm_req_i    ( dtm_req          ),
    .dtm_ready_o  ( dtm_req_ready_o  ),
    .req_o        ( gate_to_fifo     )
  );

  dmi_req_fifo i_fifo (
    .clk_i  ( clk_i        ),
    .rst_ni ( rst_ni       ),
    .req_i  ( gate_to_fifo ),
    .req_o  ( fifo_to_mem  )
  );

  dmi_mem_target i_target (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .req_i        ( fifo_to_mem  ),
    .resp_valid_o ( resp_valid_o ),
    .resp_data_o  ( resp_data_o  ),
    .resp_code_o  ( resp_code_o  ),
    .resp_ready_i ( resp_ready_i )
  );

endmodule

`default_nettype wire

// ==== sim/tb_dmi_mem_harness.sv ====
// ----------------------------------------
// Testbench for the debug-memory harness. Replays the stimulus
// file through both request ports and checks every response.
// ----------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_dmi_mem_harness;

  localparam int    ClkHalf       = 20;
  localparam int    DriveDelay    = 2;
  localparam int    ResetCycles   = 10;
  localparam int    CyclesPerLine = 64;
  localparam string StimFile      = "sim/dmi_stim_input.txt";

  // Character codes seen while scanning the stimulus file
  localparam int CharHash = 35;
  localparam int CharNl   = 10;
  localparam int CharZero = 48;
  localparam int CharOne  = 49;

  logic                          clk;
  logic                          rst_n;
  logic                          jtag_sel;
  logic                          jtag_valid;
  logic [dmi_pkg::AddrWidth-1:0] jtag_addr;
  dmi_pkg::dmi_op_e              jtag_op;
  logic [dmi_pkg::DataWidth-1:0] jtag_data;
  logic                          jtag_ready;
  logic                          dtm_valid;
  logic [dmi_pkg::AddrWidth-1:0] dtm_addr;
  dmi_pkg::dmi_op_e              dtm_op;
  logic [dmi_pkg::DataWidth-1:0] dtm_data;
  logic                          dtm_ready;
  logic                          resp_valid;
  logic [dmi_pkg::DataWidth-1:0] resp_data;
  dmi_pkg::dmi_resp_e            resp_code;
  logic                          resp_ready;

  // One entry per stimulus line
  bit                            st_sel[$];
  int                            st_op[$];
  logic [dmi_pkg::AddrWidth-1:0] st_addr[$];
  logic [dmi_pkg::DataWidth-1:0] st_wdata[$];
  int                            st_stall[$];
  logic [dmi_pkg::DataWidth-1:0] st_exp_data[$];
  logic [1:0]                    st_exp_code[$];

  // Expected responses, pushed in acceptance order
  logic [dmi_pkg::DataWidth-1:0] exp_data_q[$];
  logic [1:0]                    exp_code_q[$];

  int mismatch_cnt;
  int fail_cnt;
  int timeout_cycles;
  bit saw_full;

  dmi_mem_harness UUT (
    .clk_i            ( clk        ),
    .rst_ni           ( rst_n      ),
    .jtag_sel_i       ( jtag_sel   ),
    .jtag_req_valid_i ( jtag_valid ),
    .jtag_req_addr_i  ( jtag_addr  ),
    .jtag_req_op_i    ( jtag_op    ),
    .jtag_req_data_i  ( jtag_data  ),
    .jtag_req_ready_o ( jtag_ready ),
    .dtm_req_valid_i  ( dtm_valid  ),
    .dtm_req_addr_i   ( dtm_addr   ),
    .dtm_req_op_i     ( dtm_op     ),
    .dtm_req_data_i   ( dtm_data   ),
    .dtm_req_ready_o  ( dtm_ready  ),
    .resp_valid_o     ( resp_valid ),
    .resp_data_o      ( resp_data  ),
    .resp_code_o      ( resp_code  ),
    .resp_ready_i     ( resp_ready )
  );

  always #ClkHalf clk = ~clk;

  // ----------------------------------------
  // Stimulus file
  // ----------------------------------------
  task automatic load_stimulus();
    int                            fd;
    int                            c;
    int                            n;
    int                            op;
    int                            stall;
    int                            code;
    logic [dmi_pkg::DataWidth-1:0] addr;
    logic [dmi_pkg::DataWidth-1:0] wdata;
    logic [dmi_pkg::DataWidth-1:0] exp_data;
    fd = $fopen(StimFile, "r");
    if (fd == 0) begin
      $display("Could not open stimulus file %s", StimFile);
      fail_cnt++;
    end else begin
      c = $fgetc(fd);
      while (c != -1) begin
        if (c == CharHash) begin
          while (c != CharNl && c != -1) begin
            c = $fgetc(fd);
          end
        end else if (c == CharZero || c == CharOne) begin
          // The select digit is already consumed
          n = $fscanf(fd, "%d %h %h %d %h %d", op, addr, wdata, stall, exp_data, code);
          if (n != 6) begin
            $display("Malformed stimulus line after entry %0d", st_sel.size());
            fail_cnt++;
          end else begin
            st_sel.push_back(c == CharOne);
            st_op.push_back(op);
            st_addr.push_back(addr[dmi_pkg::AddrWidth-1:0]);
            st_wdata.push_back(wdata);
            st_stall.push_back(stall);
            st_exp_data.push_back(exp_data);
            st_exp_code.push_back(code[1:0]);
          end
        end
        if (c != -1) begin
          c = $fgetc(fd);
        end
      end
      $fclose(fd);
    end
  endtask

  // ----------------------------------------
  // Request side
  // ----------------------------------------
  task automatic present_request(int idx);
    jtag_sel = st_sel[idx];
    // The idle port offers a junk write that must never reach memory
    if (st_sel[idx]) begin
      jtag_valid = 1'b1;
      jtag_addr  = st_addr[idx];
      jtag_op    = dmi_pkg::dmi_op_e'(st_op[idx][1:0]);
      jtag_data  = st_wdata[idx];
      dtm_valid  = 1'b1;
      dtm_addr   = st_addr[idx];
      dtm_op     = dmi_pkg::DMI_WRITE;
      dtm_data   = 32'hBAD0_BAD0;
    end else begin
      dtm_valid  = 1'b1;
      dtm_addr   = st_addr[idx];
      dtm_op     = dmi_pkg::dmi_op_e'(st_op[idx][1:0]);
      dtm_data   = st_wdata[idx];
      jtag_valid = 1'b1;
      jtag_addr  = st_addr[idx];
      jtag_op    = dmi_pkg::DMI_WRITE;
      jtag_data  = 32'hBAD0_BAD0;
    end
  endtask

  task automatic drive_requests();
    int   waited;
    logic sel_ready;
    for (int i = 0; i < st_sel.size(); i++) begin
      present_request(i);
      if (i == 0) begin
        for (int k = 0; k < int'(dmi_pkg::BootHoldCycles); k++) begin
          @(negedge clk);
          if (jtag_ready || dtm_ready) begin
            $display("Request ready high inside the boot window at %0t", $time);
            fail_cnt++;
          end
        end
      end
      waited = 0;
      do begin
        @(negedge clk);
        waited++;
        if (st_sel[i] ? dtm_ready : jtag_ready) begin
          $display("Ready of the unselected port is high at %0t", $time);
          fail_cnt++;
        end
        sel_ready = st_sel[i] ? jtag_ready : dtm_ready;
        if (!sel_ready && i > 0) begin
          saw_full = 1'b1;
        end
      end while (!sel_ready);
      if (i == 0 && waited != 1) begin
        $display("Selected ready did not rise right after the boot window");
        fail_cnt++;
      end
      exp_data_q.push_back(st_exp_data[i]);
      exp_code_q.push_back(st_exp_code[i]);
      @(posedge clk);
      #DriveDelay;
    end
    jtag_valid = 1'b0;
    dtm_valid  = 1'b0;
  endtask

  // ----------------------------------------
  // Response side
  // ----------------------------------------
  task automatic compare_response(logic [dmi_pkg::DataWidth-1:0] exp_data,
                                  logic [1:0] exp_code);
    logic [1:0] code_now;
    code_now = resp_code;
    if (resp_data !== exp_data) begin
      $display("Mismatch at %0t: resp_data_o expected %08h actual %08h",
               $time, exp_data, resp_data);
      mismatch_cnt++;
    end
    if (code_now !== exp_code) begin
      $display("Mismatch at %0t: resp_code_o expected %0d actual %0d",
               $time, exp_code, code_now);
      mismatch_cnt++;
    end
  endtask

  task automatic drain_responses();
    logic [dmi_pkg::DataWidth-1:0] exp_data;
    logic [1:0]                    exp_code;
    for (int i = 0; i < st_sel.size(); i++) begin
      // A zero stall keeps ready up before the response shows
      resp_ready = (st_stall[i] == 0);
      do begin
        @(negedge clk);
      end while (!resp_valid);
      if (exp_data_q.size() == 0) begin
        $display("Response at %0t with no request outstanding", $time);
        fail_cnt++;
        exp_data = '0;
        exp_code = '0;
      end else begin
        exp_data = exp_data_q.pop_front();
        exp_code = exp_code_q.pop_front();
      end
      compare_response(exp_data, exp_code);
      if (st_stall[i] > 0) begin
        repeat (st_stall[i]) @(posedge clk);
        #DriveDelay;
        resp_ready = 1'b1;
        @(negedge clk);
        // Held response must still match after the stall
        compare_response(exp_data, exp_code);
      end
      @(posedge clk);
      #DriveDelay;
    end
    resp_ready = 1'b0;
  endtask

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    jtag_sel     = 1'b1;
    jtag_valid   = 1'b0;
    jtag_addr    = '0;
    jtag_op      = dmi_pkg::DMI_NOP;
    jtag_data    = '0;
    dtm_valid    = 1'b0;
    dtm_addr     = '0;
    dtm_op       = dmi_pkg::DMI_NOP;
    dtm_data     = '0;
    resp_ready   = 1'b0;
    mismatch_cnt = 0;
    fail_cnt     = 0;
    saw_full     = 1'b0;
    load_stimulus();
    timeout_cycles = st_sel.size() * CyclesPerLine + int'(dmi_pkg::BootHoldCycles)
                     + ResetCycles;
    fork
      begin : watchdog
        repeat (timeout_cycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles with responses missing", timeout_cycles);
        $display("Some tests failed");
        $finish;
      end
    join_none
    repeat (ResetCycles - 1) @(posedge clk);
    @(negedge clk);
    if (resp_valid || jtag_ready || dtm_ready) begin
      $display("Response valid or request ready high during reset");
      fail_cnt++;
    end
    @(posedge clk);
    #DriveDelay;
    rst_n = 1'b1;
    fork
      drive_requests();
      drain_responses();
    join
    // Every request is answered, so the response port must stay quiet
    repeat (4) begin
      @(negedge clk);
      if (resp_valid) begin
        $display("Extra response seen at %0t", $time);
        fail_cnt++;
      end
    end
    if (!saw_full) begin
      $display("Source ready never dropped under response back-pressure");
      fail_cnt++;
    end
    $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/dmi_stim_input.txt ====
# Columns: sel(1=jtag 0=dtm) op(0 nop 1 read 2 write 3 rsvd) addr(hex) wdata(hex)
# then stall cycles on resp_ready, expected data(hex), expected code(0 ok 2 failed)
# Boot hold, JTAG write then read, unwritten word
1 2 05 CAFE0005 0 00000000 0
1 1 05 00000000 0 CAFE0005 0
1 1 06 00000000 1 00000000 0
1 2 3F 12345678 2 00000000 0
1 1 3F 00000000 0 12345678 0
# DTM port and cross-port reads
0 2 10 A5A5A5A5 0 00000000 0
0 1 05 00000000 0 CAFE0005 0
0 1 10 00000000 3 A5A5A5A5 0
1 1 10 00000000 0 A5A5A5A5 0
# Out-of-range accesses and their in-range aliases
1 2 45 FFFFFFFF 0 00000000 2
1 1 45 00000000 0 00000000 2
0 2 7F 11111111 0 00000000 2
1 1 05 00000000 0 CAFE0005 0
0 1 3F 00000000 0 12345678 0
1 1 40 00000000 0 00000000 2
# Long response stall with a burst behind it
1 2 20 00000020 24 00000000 0
1 2 21 00000021 0 00000000 0
1 2 22 00000022 0 00000000 0
1 2 23 00000023 0 00000000 0
1 2 24 00000024 0 00000000 0
1 2 25 00000025 0 00000000 0
1 2 26 00000026 0 00000000 0
1 1 20 00000000 0 00000020 0
1 1 26 00000000 5 00000026 0
1 1 23 00000000 0 00000023 0
# Stall again on the DTM port
0 1 21 00000000 16 00000021 0
0 1 22 00000000 0 00000022 0
0 1 24 00000000 0 00000024 0
0 1 25 00000000 0 00000025 0
0 2 30 0BADF00D 0 00000000 0
0 1 30 00000000 0 0BADF00D 0
# NOP and reserved op leave memory alone
1 0 05 DEADBEEF 0 00000000 0
1 1 05 00000000 0 CAFE0005 0
0 3 06 FEEDFACE 2 00000000 0
0 1 06 00000000 0 00000000 0
1 0 00 00000000 0 00000000 0
1 1 00 00000000 0 00000000 0

// ==== dmi_mem_harness.f ====
hw/dmi_pkg.sv
hw/dmi_req_if.sv
hw/dmi_req_gate.sv
hw/dmi_req_fifo.sv
hw/dmi_mem_target.sv
hw/dmi_mem_harness.sv
sim/tb_dmi_mem_harness.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the harness testbench with Verilator and runs it
set -e
set -o pipefail

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG_FILE=sim.log
TOP=tb_dmi_mem_harness

verilator --binary --timing --assert \
  -Mdir "$BUILD_DIR" \
  --top-module "$TOP" \
  -f dmi_mem_harness.f \
  -o "$TOP"

"./$BUILD_DIR/$TOP" | tee "$LOG_FILE"

if grep -q "Some tests failed" "$LOG_FILE"; then
  echo "Simulation reported failures, see $LOG_FILE"
  exit 1
fi

echo "Simulation finished, log in $LOG_FILE"
